/* project.f */
source/cpu_pkg.sv
source/decode_if.sv
source/controller.sv
source/regfile.sv
source/imm_unit.sv
source/alu.sv
source/operand_select.sv
source/pc_unit.sv
source/cpu_top.sv
sim/tb_cpu.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tb_cpu -f project.f -o tb_cpu \
	&& ./obj_dir/tb_cpu > sim.log 2>&1 \
	|| { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
exit 0

/* sim/tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu;

	localparam int reset_cycles = 5;
	localparam int mem_words = 1024;
	// five programs, 50 instructions ahead of their halt loops
	localparam int run_cycles = 5 * (reset_cycles + 3) + 50 * 5;
	localparam int cycle_limit = run_cycles + 50;

	logic enable_memaccess;
	logic reset;
	logic [31:0] instruction;
	logic alu_overflow;
	logic im_read;
	logic im_write;
	logic im_enable;
	logic [9:0] im_address;
	logic dm_read;
	logic dm_write;
	logic dm_enable;
	logic [11:0] dm_address;
	logic [31:0] dm_in;
	logic [31:0] dm_out;

	logic [31:0] imem [mem_words];
	logic [31:0] dmem [mem_words];
	logic [31:0] prog [$];

	logic [cpu_pkg::im_addr_w-1:0] fetch_log [$];
	logic [cpu_pkg::dm_addr_w-1:0] acc_addr [$];
	logic [cpu_pkg::xlen-1:0] acc_data [$];
	logic acc_write [$];

	int cycle_count;
	int error_count;
	int unsigned seed_val;

	cpu_top u_dut (
		.enable_memaccess(enable_memaccess),
		.reset(reset),
		.instruction(instruction),
		.alu_overflow(alu_overflow),
		.im_read(im_read),
		.im_write(im_write),
		.im_enable(im_enable),
		.im_address(im_address),
		.dm_read(dm_read),
		.dm_write(dm_write),
		.dm_enable(dm_enable),
		.dm_address(dm_address),
		.dm_in(dm_in),
		.dm_out(dm_out)
	);

	// both memories answer in the same cycle
	assign instruction = imem[im_address];
	assign dm_out = dmem[dm_address[cpu_pkg::dm_addr_w-1:2]];

	initial begin
		enable_memaccess = 1'b0;
		forever #20 enable_memaccess = ~enable_memaccess;
	end

	always @(posedge enable_memaccess) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("timeout: the programs did not finish within %0d cycles", cycle_limit);
			$display("TEST FAILED");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	// fetch trace, data accesses and the data memory write port
	always @(negedge enable_memaccess) begin
		if (!reset) begin
			if (im_write !== 1'b0) begin
				stop_on_error("instruction memory write strobe went high");
			end
			if (im_enable && im_read) begin
				fetch_log.push_back(im_address);
			end
			if (dm_enable && dm_write) begin
				acc_addr.push_back(dm_address);
				acc_data.push_back(dm_in);
				acc_write.push_back(1'b1);
				dmem[dm_address[cpu_pkg::dm_addr_w-1:2]] = dm_in;
			end else if (dm_enable && dm_read) begin
				acc_addr.push_back(dm_address);
				acc_data.push_back(dm_out);
				acc_write.push_back(1'b0);
			end
		end
	end

	task automatic stop_on_error(string what);
		error_count = error_count + 1;
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(string name, logic [cpu_pkg::xlen-1:0] got,
		logic [cpu_pkg::xlen-1:0] exp);
		if (got !== exp) begin
			stop_on_error($sformatf("Mismatch at %0d ns: %s is %08h, expected %08h",
				$time, name, got, exp));
		end
	endtask

	task automatic check_addr(string name, logic [cpu_pkg::im_addr_w-1:0] got,
		logic [cpu_pkg::im_addr_w-1:0] exp);
		if (got !== exp) begin
			stop_on_error($sformatf("Mismatch at %0d ns: %s is %0d, expected %0d",
				$time, name, got, exp));
		end
	endtask

	task automatic check_daddr(string name, logic [cpu_pkg::dm_addr_w-1:0] got,
		logic [cpu_pkg::dm_addr_w-1:0] exp);
		if (got !== exp) begin
			stop_on_error($sformatf("Mismatch at %0d ns: %s is %03h, expected %03h",
				$time, name, got, exp));
		end
	endtask

	task automatic check_flag(string name, logic got, logic exp);
		if (got !== exp) begin
			stop_on_error($sformatf("Mismatch at %0d ns: %s is %b, expected %b",
				$time, name, got, exp));
		end
	endtask

	function automatic logic [31:0] fill_word(int idx);
		return 32'ha5000000 ^ (32'(idx) * 32'h00010101);
	endfunction

	function automatic logic [31:0] enc_alu(cpu_pkg::alu_sub_t sub, logic [4:0] rt,
		logic [4:0] ra, logic [4:0] rb);
		return {1'b0, cpu_pkg::op_alu, rt, ra, rb, 5'b00000, sub};
	endfunction

	function automatic logic [31:0] enc_imm(cpu_pkg::opcode_t op, logic [4:0] rt,
		logic [4:0] ra, logic [14:0] imm);
		return {1'b0, op, rt, ra, imm};
	endfunction

	function automatic logic [31:0] enc_branch(cpu_pkg::opcode_t op, logic [4:0] rt,
		logic [4:0] ra, logic [13:0] off);
		return {1'b0, op, rt, ra, 1'b0, off};
	endfunction

	function automatic logic [31:0] enc_jump(logic [23:0] off);
		return {1'b0, cpu_pkg::op_j, 1'b0, off};
	endfunction

	// loads prog, clears the logs and runs the core out of reset
	task automatic start_program();
		@(posedge enable_memaccess);
		reset <= 1'b1;
		for (int i = 0; i < mem_words; i++) begin
			imem[i] = '0;
			dmem[i] = fill_word(i);
		end
		foreach (prog[i]) begin
			imem[i] = prog[i];
		end
		fetch_log.delete();
		acc_addr.delete();
		acc_data.delete();
		acc_write.delete();
		repeat (reset_cycles) @(posedge enable_memaccess);
		reset <= 1'b0;
		@(negedge enable_memaccess);
		check_flag("alu_overflow", alu_overflow, 1'b0);
		check_flag("im_enable", im_enable, 1'b0);
		check_flag("im_read", im_read, 1'b0);
		check_flag("dm_enable", dm_enable, 1'b0);
		check_flag("dm_read", dm_read, 1'b0);
		check_flag("dm_write", dm_write, 1'b0);
	endtask

	task automatic wait_fetch(logic [cpu_pkg::im_addr_w-1:0] pc);
		@(negedge enable_memaccess);
		while (!(im_enable && im_address == pc)) begin
			@(negedge enable_memaccess);
		end
	endtask

	task automatic check_sequential(int n);
		if (fetch_log.size() < n) begin
			stop_on_error("fetch trace is shorter than the program");
		end
		for (int i = 0; i < n; i++) begin
			check_addr($sformatf("im_address of fetch %0d", i), fetch_log[i], 10'(i));
		end
	endtask

	task automatic check_access(int idx, logic wr, logic [cpu_pkg::dm_addr_w-1:0] addr,
		logic [cpu_pkg::xlen-1:0] data);
		if (acc_addr.size() <= idx) begin
			stop_on_error($sformatf("data memory access %0d never happened", idx));
		end
		check_flag($sformatf("dm_write of access %0d", idx), acc_write[idx], wr);
		check_daddr($sformatf("dm_address of access %0d", idx), acc_addr[idx], addr);
		check_word(wr ? "dm_in" : "dm_out", acc_data[idx], data);
	endtask

	task automatic test_arith();
		logic [14:0] a;
		logic [14:0] b;
		logic [14:0] c;
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] exp_vals [7];
		a = 15'($urandom);
		b = 15'($urandom);
		c = 15'($urandom);
		r1 = {{17{a[14]}}, a};
		r2 = {17'b0, b} ^ {17'b0, c};
		exp_vals = '{r1, r2, r1 + r2, r1 - r2, r1 & r2, r1 | r2, r1 ^ r2};
		prog.delete();
		prog.push_back(enc_imm(cpu_pkg::op_addi, 5'd1, 5'd0, a));
		prog.push_back(enc_imm(cpu_pkg::op_ori, 5'd2, 5'd0, b));
		prog.push_back(enc_imm(cpu_pkg::op_xori, 5'd2, 5'd2, c));
		prog.push_back(enc_alu(cpu_pkg::sub_add, 5'd3, 5'd1, 5'd2));
		prog.push_back(enc_alu(cpu_pkg::sub_sub, 5'd4, 5'd1, 5'd2));
		prog.push_back(enc_alu(cpu_pkg::sub_and, 5'd5, 5'd1, 5'd2));
		prog.push_back(enc_alu(cpu_pkg::sub_or, 5'd6, 5'd1, 5'd2));
		prog.push_back(enc_alu(cpu_pkg::sub_xor, 5'd7, 5'd1, 5'd2));
		for (int k = 0; k < 7; k++) begin
			prog.push_back(enc_imm(cpu_pkg::op_swi, 5'(k + 1), 5'd0, 15'(12'h100 + 4 * k)));
		end
		prog.push_back(enc_jump(24'd0));
		start_program();
		wait_fetch(10'd15);
		check_sequential(15);
		for (int k = 0; k < 7; k++) begin
			check_access(k, 1'b1, 12'(12'h100 + 4 * k), exp_vals[k]);
			check_word($sformatf("dmem word %0d", 64 + k), dmem[64 + k], exp_vals[k]);
		end
	endtask

	task automatic test_shifts();
		logic [14:0] a;
		logic [14:0] b;
		logic [4:0] s [3];
		logic [31:0] r1;
		logic [31:0] exp_vals [4];
		a = 15'($urandom);
		b = 15'($urandom);
		for (int k = 0; k < 3; k++) begin
			s[k] = 5'($urandom);
		end
		r1 = ({{17{a[14]}}, a} << 17) ^ {17'b0, b};
		exp_vals = '{r1, r1 << s[0], r1 >> s[1], r1 >> s[2]};
		prog.delete();
		prog.push_back(enc_imm(cpu_pkg::op_addi, 5'd1, 5'd0, a));
		prog.push_back(enc_alu(cpu_pkg::sub_slli, 5'd1, 5'd1, 5'd17));
		prog.push_back(enc_imm(cpu_pkg::op_xori, 5'd1, 5'd1, b));
		prog.push_back(enc_alu(cpu_pkg::sub_slli, 5'd2, 5'd1, s[0]));
		prog.push_back(enc_alu(cpu_pkg::sub_srli, 5'd3, 5'd1, s[1]));
		prog.push_back(enc_alu(cpu_pkg::sub_srli, 5'd4, 5'd1, s[2]));
		for (int k = 0; k < 4; k++) begin
			prog.push_back(enc_imm(cpu_pkg::op_swi, 5'(k + 1), 5'd0, 15'(12'h200 + 4 * k)));
		end
		prog.push_back(enc_jump(24'd0));
		start_program();
		wait_fetch(10'd10);
		check_sequential(10);
		for (int k = 0; k < 4; k++) begin
			check_access(k, 1'b1, 12'(12'h200 + 4 * k), exp_vals[k]);
		end
	endtask

	task automatic test_load_store();
		int base;
		int off_ld [3];
		int off_st [3];
		logic [31:0] vals [3];
		base = 'h300;
		off_ld = '{8, -4, 'h40};
		off_st = '{'h100, -8, 'h104};
		prog.delete();
		prog.push_back(enc_imm(cpu_pkg::op_addi, 5'd1, 5'd0, 15'(base)));
		for (int k = 0; k < 3; k++) begin
			prog.push_back(enc_imm(cpu_pkg::op_lwi, 5'(k + 2), 5'd1, 15'(off_ld[k])));
		end
		for (int k = 0; k < 3; k++) begin
			prog.push_back(enc_imm(cpu_pkg::op_swi, 5'(k + 2), 5'd1, 15'(off_st[k])));
		end
		prog.push_back(enc_jump(24'd0));
		start_program();
		for (int k = 0; k < 3; k++) begin
			vals[k] = $urandom;
			dmem[(base + off_ld[k]) / 4] = vals[k];
		end
		wait_fetch(10'd7);
		check_sequential(7);
		for (int k = 0; k < 3; k++) begin
			check_access(k, 1'b0, 12'(base + off_ld[k]), vals[k]);
			check_access(k + 3, 1'b1, 12'(base + off_st[k]), vals[k]);
			check_word("copied word", dmem[(base + off_st[k]) / 4], vals[k]);
		end
	endtask

	task automatic test_branches();
		logic [cpu_pkg::im_addr_w-1:0] exp_pc [10];
		int skipped [6];
		// 3 beq taken +2, 5 bne taken +3, 8 and 9 fall through, 10 j +5, 16 j -4
		exp_pc = '{10'd0, 10'd1, 10'd2, 10'd3, 10'd5, 10'd8, 10'd9, 10'd10, 10'd15, 10'd16};
		skipped = '{'h500, 'h504, 'h508, 'h510, 'h514, 'h518};
		prog.delete();
		prog.push_back(enc_imm(cpu_pkg::op_addi, 5'd1, 5'd0, 15'd5));
		prog.push_back(enc_imm(cpu_pkg::op_addi, 5'd2, 5'd0, 15'd5));
		prog.push_back(enc_imm(cpu_pkg::op_addi, 5'd3, 5'd0, 15'd7));
		prog.push_back(enc_branch(cpu_pkg::op_beq, 5'd1, 5'd2, 14'd2));
		prog.push_back(enc_imm(cpu_pkg::op_swi, 5'd1, 5'd0, 15'h500));
		prog.push_back(enc_branch(cpu_pkg::op_bne, 5'd1, 5'd3, 14'd3));
		prog.push_back(enc_imm(cpu_pkg::op_swi, 5'd1, 5'd0, 15'h504));
		prog.push_back(enc_imm(cpu_pkg::op_swi, 5'd1, 5'd0, 15'h508));
		prog.push_back(enc_branch(cpu_pkg::op_beq, 5'd1, 5'd3, 14'd5));
		prog.push_back(enc_branch(cpu_pkg::op_bne, 5'd1, 5'd2, 14'd5));
		prog.push_back(enc_jump(24'd5));
		prog.push_back(enc_imm(cpu_pkg::op_swi, 5'd1, 5'd0, 15'h510));
		prog.push_back(enc_jump(24'd0));
		prog.push_back(enc_imm(cpu_pkg::op_swi, 5'd1, 5'd0, 15'h514));
		prog.push_back(enc_imm(cpu_pkg::op_swi, 5'd1, 5'd0, 15'h518));
		prog.push_back(enc_imm(cpu_pkg::op_swi, 5'd3, 5'd0, 15'h50c));
		prog.push_back(enc_jump(-24'sd4));
		start_program();
		wait_fetch(10'd12);
		if (fetch_log.size() < 10) begin
			stop_on_error("fetch trace is shorter than the taken path");
		end
		for (int i = 0; i < 10; i++) begin
			check_addr($sformatf("im_address of fetch %0d", i), fetch_log[i], exp_pc[i]);
		end
		if (acc_addr.size() != 1) begin
			stop_on_error("skipped instructions reached the data memory");
		end
		check_access(0, 1'b1, 12'h50c, 32'd7);
		foreach (skipped[k]) begin
			check_word("untouched word", dmem[skipped[k] / 4], fill_word(skipped[k] / 4));
		end
	endtask

	task automatic test_overflow_r0();
		logic [31:0] r1;
		logic [31:0] sum;
		r1 = 32'h3fff << 17;
		sum = r1 + r1;
		prog.delete();
		prog.push_back(enc_imm(cpu_pkg::op_addi, 5'd1, 5'd0, 15'h3fff));
		prog.push_back(enc_alu(cpu_pkg::sub_slli, 5'd1, 5'd1, 5'd17));
		prog.push_back(enc_alu(cpu_pkg::sub_add, 5'd2, 5'd1, 5'd1));
		prog.push_back(enc_alu(cpu_pkg::sub_add, 5'd3, 5'd1, 5'd0));
		prog.push_back(enc_imm(cpu_pkg::op_addi, 5'd0, 5'd0, 15'd123));
		prog.push_back(enc_imm(cpu_pkg::op_swi, 5'd0, 5'd0, 15'h600));
		prog.push_back(enc_imm(cpu_pkg::op_swi, 5'd2, 5'd0, 15'h604));
		prog.push_back(enc_imm(cpu_pkg::op_swi, 5'd3, 5'd0, 15'h608));
		prog.push_back(enc_jump(24'd0));
		start_program();
		wait_fetch(10'd2);
		check_flag("alu_overflow", alu_overflow, 1'b0);
		// two large positive operands give a negative sum
		wait_fetch(10'd3);
		check_flag("alu_overflow", alu_overflow, 1'b1);
		wait_fetch(10'd4);
		check_flag("alu_overflow", alu_overflow, 1'b0);
		wait_fetch(10'd8);
		check_sequential(8);
		check_access(0, 1'b1, 12'h600, 32'd0);
		check_access(1, 1'b1, 12'h604, sum);
		check_access(2, 1'b1, 12'h608, r1);
	endtask

	initial begin
		reset = 1'b1;
		cycle_count = 0;
		error_count = 0;
		for (int i = 0; i < mem_words; i++) begin
			imem[i] = '0;
			dmem[i] = fill_word(i);
		end
		seed_val = $urandom(32'hec197a20);
		test_arith();
		test_shifts();
		test_load_store();
		test_branches();
		test_overflow_r0();
		if (error_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* source/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top (
	input  logic enable_memaccess,
	input  logic reset,
	input  logic [31:0] instruction,
	output logic alu_overflow,
	output logic im_read,
	output logic im_write,
	output logic im_enable,
	output logic [9:0] im_address,
	output logic dm_read,
	output logic dm_write,
	output logic dm_enable,
	output logic [11:0] dm_address,
	output logic [31:0] dm_in,
	input  logic [31:0] dm_out
);

	decode_if dec ();

	logic phase_fetch;
	logic phase_decode;
	logic phase_exec;
	logic phase_mem;
	logic phase_wb;
	logic alu_zero;
	logic alu_ovf;
	logic [cpu_pkg::xlen-1:0] ra_data;
	logic [cpu_pkg::xlen-1:0] rb_data;
	logic [cpu_pkg::xlen-1:0] rt_data;
	logic [cpu_pkg::xlen-1:0] imm_value;
	logic [cpu_pkg::xlen-1:0] alu_src2;
	logic [cpu_pkg::xlen-1:0] alu_result;
	logic [cpu_pkg::xlen-1:0] alu_result_q;
	logic [cpu_pkg::xlen-1:0] load_data_q;
	logic [cpu_pkg::xlen-1:0] write_data;
	logic [cpu_pkg::im_addr_w-1:0] current_pc;
	logic [cpu_pkg::im_addr_w-1:0] next_pc;

	// execute result held for memory access and writeback
	always_ff @(posedge enable_memaccess) begin
		if (reset) begin
			alu_result_q <= '0;
			alu_overflow <= 1'b0;
		end else if (phase_exec) begin
			alu_result_q <= alu_result;
			alu_overflow <= alu_ovf;
		end
	end

	always_ff @(posedge enable_memaccess) begin
		if (reset) begin
			load_data_q <= '0;
		end else if (phase_mem) begin
			load_data_q <= dm_out;
		end
	end

	assign im_enable = phase_fetch;
	assign im_address = current_pc;
	assign dm_enable = dm_read | dm_write;
	assign dm_address = alu_result_q[cpu_pkg::dm_addr_w-1:0];
	assign dm_in = rt_data;

	controller u_ctrl (
		.enable_memaccess(enable_memaccess),
		.reset(reset),
		.instruction(instruction),
		.alu_zero(alu_zero),
		.dec(dec.ctrl),
		.phase_fetch(phase_fetch),
		.phase_decode(phase_decode),
		.phase_exec(phase_exec),
		.phase_mem(phase_mem),
		.phase_wb(phase_wb),
		.im_read(im_read),
		.im_write(im_write),
		.dm_read(dm_read),
		.dm_write(dm_write)
	);

	regfile u_regs (
		.enable_memaccess(enable_memaccess),
		.reset(reset),
		.phase_decode(phase_decode),
		.phase_wb(phase_wb),
		.regs(dec.regs),
		.write_data(write_data),
		.ra_data(ra_data),
		.rb_data(rb_data),
		.rt_data(rt_data)
	);

	imm_unit u_imm (
		.imm(dec.imm),
		.imm_value(imm_value)
	);

	alu u_alu (
		.exe(dec.exe),
		.src1(ra_data),
		.src2(alu_src2),
		.result(alu_result),
		.zero(alu_zero),
		.overflow(alu_ovf)
	);

	operand_select u_sel (
		.sel(dec.sel),
		.instruction(dec.instr),
		.rb_data(rb_data),
		.imm_value(imm_value),
		.alu_result_q(alu_result_q),
		.load_data(load_data_q),
		.current_pc(current_pc),
		.alu_src2(alu_src2),
		.write_data(write_data),
		.next_pc(next_pc)
	);

	pc_unit u_pc (
		.enable_memaccess(enable_memaccess),
		.reset(reset),
		.phase_exec(phase_exec),
		.next_pc(next_pc),
		.current_pc(current_pc)
	);

endmodule

/* source/pc_unit.sv */
`timescale 1ns/1ps

module pc_unit (
	input  logic enable_memaccess,
	input  logic reset,
	input  logic phase_exec,
	input  logic [cpu_pkg::im_addr_w-1:0] next_pc,
	output logic [cpu_pkg::im_addr_w-1:0] current_pc
);

	logic [cpu_pkg::im_addr_w-1:0] pc_q;

	// pc moves only at the end of execute
	always_ff @(posedge enable_memaccess) begin
		if (reset) begin
			pc_q <= '0;
		end else if (phase_exec) begin
			pc_q <= next_pc;
		end
	end

	assign current_pc = pc_q;

endmodule

/* source/operand_select.sv */
`timescale 1ns/1ps

module operand_select (
	decode_if.sel sel,
	input  logic [cpu_pkg::xlen-1:0] instruction,
	input  logic [cpu_pkg::xlen-1:0] rb_data,
	input  logic [cpu_pkg::xlen-1:0] imm_value,
	input  logic [cpu_pkg::xlen-1:0] alu_result_q,
	input  logic [cpu_pkg::xlen-1:0] load_data,
	input  logic [cpu_pkg::im_addr_w-1:0] current_pc,
	output logic [cpu_pkg::xlen-1:0] alu_src2,
	output logic [cpu_pkg::xlen-1:0] write_data,
	output logic [cpu_pkg::im_addr_w-1:0] next_pc
);

	logic signed [cpu_pkg::xlen-1:0] br_off;
	logic signed [cpu_pkg::xlen-1:0] jmp_off;

	assign alu_src2 = (sel.src2_sel == cpu_pkg::src2_imm) ? imm_value : rb_data;
	assign write_data = (sel.wb_sel == cpu_pkg::wb_load) ? load_data : alu_result_q;

	// word offsets sign extended to full width
	assign br_off = $signed(instruction[cpu_pkg::br_msb:cpu_pkg::br_lsb]);
	assign jmp_off = $signed(instruction[cpu_pkg::jmp_msb:cpu_pkg::jmp_lsb]);

	// targets wrap within instruction memory
	always_comb begin
		case (sel.pc_sel)
			cpu_pkg::pc_branch: begin
				next_pc = current_pc + br_off[cpu_pkg::im_addr_w-1:0];
			end
			cpu_pkg::pc_jump: begin
				next_pc = current_pc + jmp_off[cpu_pkg::im_addr_w-1:0];
			end
			default: begin
				next_pc = current_pc + 1'b1;
			end
		endcase
	end

endmodule

/* source/alu.sv */
`timescale 1ns/1ps

module alu (
	decode_if.exe exe,
	input  logic [cpu_pkg::xlen-1:0] src1,
	input  logic [cpu_pkg::xlen-1:0] src2,
	output logic [cpu_pkg::xlen-1:0] result,
	output logic zero,
	output logic overflow
);

	logic [cpu_pkg::xlen-1:0] sum;
	logic [cpu_pkg::xlen-1:0] diff;
	logic [4:0] shamt;
	logic sign_a;
	logic sign_b;

	assign sum = src1 + src2;
	assign diff = src1 - src2;
	assign shamt = src2[4:0];
	assign sign_a = src1[cpu_pkg::xlen-1];
	assign sign_b = src2[cpu_pkg::xlen-1];

	always_comb begin
		case (exe.alu_op)
			cpu_pkg::alu_add: result = sum;
			cpu_pkg::alu_sub: result = diff;
			cpu_pkg::alu_and: result = src1 & src2;
			cpu_pkg::alu_or:  result = src1 | src2;
			cpu_pkg::alu_xor: result = src1 ^ src2;
			cpu_pkg::alu_sll: result = src1 << shamt;
			cpu_pkg::alu_srl: result = src1 >> shamt;
			default: result = '0;
		endcase
	end

	// signed overflow when the result sign cannot be right
	always_comb begin
		case (exe.alu_op)
			cpu_pkg::alu_add: begin
				overflow = (sign_a == sign_b) && (sum[cpu_pkg::xlen-1] != sign_a);
			end
			cpu_pkg::alu_sub: begin
				overflow = (sign_a != sign_b) && (diff[cpu_pkg::xlen-1] != sign_a);
			end
			default: overflow = 1'b0;
		endcase
	end

	assign zero = (result == '0);

endmodule

/* source/imm_unit.sv */
`timescale 1ns/1ps

module imm_unit (
	decode_if.imm imm,
	output logic [cpu_pkg::xlen-1:0] imm_value
);

	logic [14:0] imm15;
	logic [4:0] shamt;
	logic [13:0] br14;

	assign imm15 = imm.instr[cpu_pkg::imm15_msb:cpu_pkg::imm15_lsb];
	assign shamt = imm.instr[cpu_pkg::sh_msb:cpu_pkg::sh_lsb];
	assign br14 = imm.instr[cpu_pkg::br_msb:cpu_pkg::br_lsb];

	always_comb begin
		case (imm.imm_fmt)
			cpu_pkg::imm_s15: begin
				imm_value = {{(cpu_pkg::xlen-15){imm15[14]}}, imm15};
			end
			cpu_pkg::imm_u15: begin
				imm_value = {{(cpu_pkg::xlen-15){1'b0}}, imm15};
			end
			cpu_pkg::imm_u5: begin
				imm_value = {{(cpu_pkg::xlen-5){1'b0}}, shamt};
			end
			// signed branch offset
			default: begin
				imm_value = {{(cpu_pkg::xlen-14){br14[13]}}, br14};
			end
		endcase
	end

endmodule

/* source/regfile.sv */
`timescale 1ns/1ps

module regfile (
	input  logic enable_memaccess,
	input  logic reset,
	input  logic phase_decode,
	input  logic phase_wb,
	decode_if.regs regs,
	input  logic [cpu_pkg::xlen-1:0] write_data,
	output logic [cpu_pkg::xlen-1:0] ra_data,
	output logic [cpu_pkg::xlen-1:0] rb_data,
	output logic [cpu_pkg::xlen-1:0] rt_data
);

	logic [cpu_pkg::xlen-1:0] rf [32];

	// r0 is never written, so it always reads as zero
	always_ff @(posedge enable_memaccess) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				rf[i] <= '0;
			end
		end else if (phase_wb && regs.do_reg_write && regs.rt != '0) begin
			rf[regs.rt] <= write_data;
		end
	end

	// operands held from decode through writeback
	always_ff @(posedge enable_memaccess) begin
		if (reset) begin
			ra_data <= '0;
			rb_data <= '0;
			rt_data <= '0;
		end else if (phase_decode) begin
			ra_data <= rf[regs.ra];
			rb_data <= rf[regs.rb];
			rt_data <= rf[regs.rt];
		end
	end

endmodule

/* source/controller.sv */
`timescale 1ns/1ps

module controller (
	input  logic enable_memaccess,
	input  logic reset,
	input  logic [cpu_pkg::xlen-1:0] instruction,
	input  logic alu_zero,
	decode_if.ctrl dec,
	output logic phase_fetch,
	output logic phase_decode,
	output logic phase_exec,
	output logic phase_mem,
	output logic phase_wb,
	output logic im_read,
	output logic im_write,
	output logic dm_read,
	output logic dm_write
);

	logic [4:0] phase_q;
	logic [cpu_pkg::xlen-1:0] ir;
	cpu_pkg::opcode_t opcode;
	cpu_pkg::alu_sub_t sub_op;
	logic is_branch;
	logic is_load;
	logic is_store;

	// idle after reset, then fetch .. wb in a ring
	always_ff @(posedge enable_memaccess) begin
		if (reset) begin
			phase_q <= 5'b00000;
		end else if (phase_q == 5'b00000 || phase_q[4]) begin
			phase_q <= 5'b00001;
		end else begin
			phase_q <= phase_q << 1;
		end
	end

	always_ff @(posedge enable_memaccess) begin
		if (reset) begin
			ir <= '0;
		end else if (phase_fetch) begin
			ir <= instruction;
		end
	end

	assign phase_fetch = phase_q[0];
	assign phase_decode = phase_q[1];
	assign phase_exec = phase_q[2];
	assign phase_mem = phase_q[3];
	assign phase_wb = phase_q[4];

	assign opcode = cpu_pkg::opcode_t'(ir[cpu_pkg::op_msb:cpu_pkg::op_lsb]);
	assign sub_op = cpu_pkg::alu_sub_t'(ir[cpu_pkg::sub_msb:cpu_pkg::sub_lsb]);
	assign is_branch = (opcode == cpu_pkg::op_beq) || (opcode == cpu_pkg::op_bne);

	// branches compare rt against ra, so rt goes out on the rb read port
	assign dec.ra = ir[cpu_pkg::ra_msb:cpu_pkg::ra_lsb];
	assign dec.rb = is_branch ? ir[cpu_pkg::rt_msb:cpu_pkg::rt_lsb]
		: ir[cpu_pkg::rb_msb:cpu_pkg::rb_lsb];
	assign dec.rt = ir[cpu_pkg::rt_msb:cpu_pkg::rt_lsb];
	assign dec.instr = ir;

	always_comb begin
		dec.alu_op = cpu_pkg::alu_add;
		dec.src2_sel = cpu_pkg::src2_rb;
		dec.imm_fmt = cpu_pkg::imm_s15;
		dec.wb_sel = cpu_pkg::wb_alu;
		dec.pc_sel = cpu_pkg::pc_seq;
		dec.do_reg_write = 1'b0;
		is_load = 1'b0;
		is_store = 1'b0;
		case (opcode)
			cpu_pkg::op_alu: begin
				dec.do_reg_write = 1'b1;
				case (sub_op)
					cpu_pkg::sub_add: dec.alu_op = cpu_pkg::alu_add;
					cpu_pkg::sub_sub: dec.alu_op = cpu_pkg::alu_sub;
					cpu_pkg::sub_and: dec.alu_op = cpu_pkg::alu_and;
					cpu_pkg::sub_or:  dec.alu_op = cpu_pkg::alu_or;
					cpu_pkg::sub_xor: dec.alu_op = cpu_pkg::alu_xor;
					cpu_pkg::sub_slli, cpu_pkg::sub_srli: begin
						dec.alu_op = (sub_op == cpu_pkg::sub_slli) ? cpu_pkg::alu_sll
							: cpu_pkg::alu_srl;
						dec.src2_sel = cpu_pkg::src2_imm;
						dec.imm_fmt = cpu_pkg::imm_u5;
					end
					// unknown sub-op does nothing
					default: dec.do_reg_write = 1'b0;
				endcase
			end
			cpu_pkg::op_addi, cpu_pkg::op_ori, cpu_pkg::op_xori: begin
				dec.do_reg_write = 1'b1;
				dec.src2_sel = cpu_pkg::src2_imm;
				if (opcode == cpu_pkg::op_addi) begin
					dec.alu_op = cpu_pkg::alu_add;
				end else begin
					dec.imm_fmt = cpu_pkg::imm_u15;
					dec.alu_op = (opcode == cpu_pkg::op_ori) ? cpu_pkg::alu_or
						: cpu_pkg::alu_xor;
				end
			end
			cpu_pkg::op_lwi: begin
				dec.src2_sel = cpu_pkg::src2_imm;
				dec.wb_sel = cpu_pkg::wb_load;
				dec.do_reg_write = 1'b1;
				is_load = 1'b1;
			end
			cpu_pkg::op_swi: begin
				dec.src2_sel = cpu_pkg::src2_imm;
				is_store = 1'b1;
			end
			cpu_pkg::op_beq, cpu_pkg::op_bne: begin
				dec.alu_op = cpu_pkg::alu_sub;
				dec.imm_fmt = cpu_pkg::imm_s14;
				// taken when equality matches the branch sense
				if (alu_zero == (opcode == cpu_pkg::op_beq)) begin
					dec.pc_sel = cpu_pkg::pc_branch;
				end
			end
			cpu_pkg::op_j: dec.pc_sel = cpu_pkg::pc_jump;
			default: ;
		endcase
	end

	assign im_read = phase_fetch;
	assign im_write = 1'b0;
	assign dm_read = phase_mem & is_load;
	assign dm_write = phase_mem & is_store;

endmodule

/* source/decode_if.sv */
`timescale 1ns/1ps

interface decode_if;
	logic [cpu_pkg::reg_addr_w-1:0] ra;
	logic [cpu_pkg::reg_addr_w-1:0] rb;
	logic [cpu_pkg::reg_addr_w-1:0] rt;
	logic [cpu_pkg::xlen-1:0] instr;
	logic do_reg_write;
	cpu_pkg::alu_op_t alu_op;
	cpu_pkg::src2_sel_t src2_sel;
	cpu_pkg::imm_fmt_t imm_fmt;
	cpu_pkg::wb_sel_t wb_sel;
	cpu_pkg::pc_sel_t pc_sel;

	modport ctrl (
		output ra, rb, rt, instr, do_reg_write,
		output alu_op, src2_sel, imm_fmt, wb_sel, pc_sel
	);
	modport regs (input ra, rb, rt, do_reg_write);
	modport imm (input instr, imm_fmt);
	modport sel (input src2_sel, wb_sel, pc_sel);
	modport exe (input alu_op);
endinterface

/* source/cpu_pkg.sv */
package cpu_pkg;

	localparam int xlen = 32;
	localparam int im_addr_w = 10;
	localparam int dm_addr_w = 12;
	localparam int reg_addr_w = 5;

	// instruction field positions
	localparam int op_msb = 30;
	localparam int op_lsb = 25;
	localparam int rt_msb = 24;
	localparam int rt_lsb = 20;
	localparam int ra_msb = 19;
	localparam int ra_lsb = 15;
	localparam int rb_msb = 14;
	localparam int rb_lsb = 10;
	localparam int sh_msb = 14;
	localparam int sh_lsb = 10;
	localparam int sub_msb = 4;
	localparam int sub_lsb = 0;
	localparam int imm15_msb = 14;
	localparam int imm15_lsb = 0;
	localparam int br_msb = 13;
	localparam int br_lsb = 0;
	localparam int jmp_msb = 23;
	localparam int jmp_lsb = 0;

	typedef enum logic [5:0] {
		op_alu  = 6'b100000,
		op_addi = 6'b101000,
		op_ori  = 6'b101100,
		op_xori = 6'b101011,
		op_lwi  = 6'b000010,
		op_swi  = 6'b001010,
		op_beq  = 6'b100110,
		op_bne  = 6'b100111,
		op_j    = 6'b100100
	} opcode_t;

	typedef enum logic [4:0] {
		sub_add  = 5'b00000,
		sub_sub  = 5'b00001,
		sub_and  = 5'b00010,
		sub_xor  = 5'b00011,
		sub_or   = 5'b00100,
		sub_slli = 5'b01000,
		sub_srli = 5'b01001
	} alu_sub_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_sll,
		alu_srl
	} alu_op_t;

	typedef enum logic {src2_rb, src2_imm} src2_sel_t;

	typedef enum logic [1:0] {imm_s15, imm_u15, imm_u5, imm_s14} imm_fmt_t;

	typedef enum logic {wb_alu, wb_load} wb_sel_t;

	typedef enum logic [1:0] {pc_seq, pc_branch, pc_jump} pc_sel_t;

endpackage
